// File: Makefile
TOOL       := verilator
TOP        := uart_rx_tb
FLIST      := vlog.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := TEST RESULT: FAIL
PASS_MSG   := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/uart_baud_gen.sv
// Sample tick generator for the UART receiver.
// Restarts at half a bit on a start edge, then ticks once per bit.

`include "uart_params.svh"

`default_nettype none

module uart_baud_gen (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en_i,
  input  uart_pkg::baud_div_t baud_div_i,
  input  logic                restart_i,
  output logic                tick_o
);

  uart_pkg::baud_div_t cnt_q;
  uart_pkg::baud_div_t half_div;
  logic                wrap;

  // Loading half the divisor puts the first tick in the middle of the start bit.
  assign half_div = baud_div_i >> 1;
  assign wrap     = (cnt_q == baud_div_i - 16'd1);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else if (!en_i) begin
      // Held at zero and silent while the receiver is off.
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else if (restart_i) begin
      cnt_q  <= half_div;
      tick_o <= 1'b0;
    end else if (wrap) begin
      cnt_q  <= '0;
      tick_o <= 1'b1;
    end else begin
      cnt_q  <= cnt_q + 16'd1;
      tick_o <= 1'b0;
    end
  end

  // With a divisor of two or more there is always a gap between ticks,
  // even when a restart lands right after one.
  a_tick_single : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (tick_o && baud_div_i >= 16'd2) |=> !tick_o
  ) else $error("tick_o high on two consecutive cycles");

endmodule

`default_nettype wire

// File: hw/uart_pkg.sv
// Shared types for the UART receiver.
// Data and divisor vectors, the received-frame struct and the
// deserializer state encoding.

`include "uart_params.svh"

`default_nettype none

package uart_pkg;

  // One received character.
  typedef logic [`UART_DATA_W-1:0] data_t;

  // Clock cycles per bit on the serial line.
  typedef logic [15:0] baud_div_t;

  // Entry stored in the receive FIFO.
  typedef struct packed {
    data_t data;
    logic  frame_err;
  } rx_frame_t;

  // Deserializer states.
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } rx_state_e;

endpackage

`default_nettype wire

// File: hw/uart_rx_deser.sv
// UART receive deserializer.
// Line synchronizer, falling-edge start detection, bit-sampling FSM
// and assembly of the received frame with its framing-error flag.

`include "uart_params.svh"

`default_nettype none

module uart_rx_deser (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en_i,
  input  logic                rx_i,
  input  logic                tick_i,
  output logic                restart_o,
  output uart_pkg::rx_frame_t frame_o,
  output logic                frame_valid_o
);

  localparam int unsigned CNT_W = $clog2(`UART_DATA_W);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`UART_DATA_W - 1);

  logic [`UART_SYNC_STAGES-1:0] sync_q;
  logic                         line;
  logic                         line_q;
  logic                         fall;
  logic                         sample;

  uart_pkg::rx_state_e state_q;
  logic [CNT_W-1:0]    bit_cnt_q;
  uart_pkg::data_t     shift_q;

  // Synchronizer and edge detector. Idle line is high.
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sync_q <= '1;
      line_q <= 1'b1;
    end else begin
      sync_q <= {sync_q[`UART_SYNC_STAGES-2:0], rx_i};
      line_q <= line;
    end
  end

  assign line   = sync_q[`UART_SYNC_STAGES-1];
  assign fall   = line_q & ~line;
  assign sample = en_i & tick_i;

  // A start edge realigns the baud generator to this bit.
  assign restart_o = en_i && (state_q == uart_pkg::IDLE) && fall;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q       <= uart_pkg::IDLE;
      bit_cnt_q     <= '0;
      frame_valid_o <= 1'b0;
    end else begin
      frame_valid_o <= 1'b0;
      if (!en_i) begin
        state_q <= uart_pkg::IDLE;
      end else begin
        case (state_q)
          uart_pkg::IDLE: begin
            if (fall) begin
              state_q <= uart_pkg::START;
            end
          end
          uart_pkg::START: begin
            // Line back high at mid-bit means it was only a glitch.
            if (tick_i) begin
              if (line) begin
                state_q <= uart_pkg::IDLE;
              end else begin
                state_q   <= uart_pkg::DATA;
                bit_cnt_q <= '0;
              end
            end
          end
          uart_pkg::DATA: begin
            if (tick_i) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q == LAST_BIT) begin
                state_q <= uart_pkg::STOP;
              end
            end
          end
          uart_pkg::STOP: begin
            if (tick_i) begin
              frame_valid_o <= 1'b1;
              state_q       <= uart_pkg::IDLE;
            end
          end
        endcase
      end
    end
  end

  // Data path. Bits arrive LSB first, so shift in from the top.
  always_ff @(posedge clk_i) begin
    if (sample && state_q == uart_pkg::DATA) begin
      shift_q <= {line, shift_q[`UART_DATA_W-1:1]};
    end
    if (sample && state_q == uart_pkg::STOP) begin
      frame_o.data      <= shift_q;
      frame_o.frame_err <= ~line;
    end
  end

  a_valid_pulse : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    frame_valid_o |=> !frame_valid_o
  ) else $error("frame_valid_o held for more than one cycle");

  // Each start edge gives a single restart pulse.
  a_restart_pulse : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    restart_o |=> !restart_o
  ) else $error("restart_o held for more than one cycle");

endmodule

`default_nettype wire

// File: hw/uart_rx_fifo.sv
// First-word-fall-through FIFO for received UART frames.
// Reports full and empty, and pulses overrun when a frame is dropped.

`include "uart_params.svh"

`default_nettype none

module uart_rx_fifo #(
  parameter int unsigned DEPTH = `UART_FIFO_DEPTH
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                wr_i,
  input  uart_pkg::rx_frame_t wdata_i,
  input  logic                rd_i,
  output uart_pkg::rx_frame_t rdata_o,
  output logic                empty_o,
  output logic                full_o,
  output logic                overrun_o
);

  localparam int unsigned AW = $clog2(DEPTH);

  if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
    $error("uart_rx_fifo DEPTH must be a power of two, at least 2");
  end

  uart_pkg::rx_frame_t mem_q [DEPTH];

  // Extra top bit tells a full FIFO from an empty one.
  logic [AW:0] wr_ptr_q;
  logic [AW:0] rd_ptr_q;
  logic [AW:0] level;
  logic        wr_en;
  logic        rd_en;

  assign level   = wr_ptr_q - rd_ptr_q;
  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                   (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

  // A read on an empty FIFO is ignored.
  assign rd_en = rd_i && !empty_o;

  // When full, a same-cycle read frees the slot for the incoming frame.
  assign wr_en     = wr_i && (!full_o || rd_en);
  assign overrun_o = wr_i && full_o && !rd_en;

  // Head entry straight from storage.
  assign rdata_o = mem_q[rd_ptr_q[AW-1:0]];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q[AW-1:0]] <= wdata_i;
    end
  end

  a_level_max : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    level <= (AW + 1)'(DEPTH)
  ) else $error("FIFO occupancy %0d exceeds depth %0d", level, DEPTH);

endmodule

`default_nettype wire

// File: hw/uart_rx_top.sv
// UART receive subsystem top level.
// Deserializer with line synchronizer, baud tick generator and
// frame FIFO read by the host with a plain strobe.

`include "uart_params.svh"

`default_nettype none

module uart_rx_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                rx_en_i,
  input  uart_pkg::baud_div_t baud_div_i,
  input  logic                rx_i,
  input  logic                rx_re_i,
  output uart_pkg::rx_frame_t rdata_o,
  output logic                empty_o,
  output logic                full_o,
  output logic                overrun_o
);

  logic                restart;
  logic                tick;
  uart_pkg::rx_frame_t frame;
  logic                frame_valid;

  // Serial line to frames.
  uart_rx_deser u_deser (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .en_i         (rx_en_i),
    .rx_i         (rx_i),
    .tick_i       (tick),
    .restart_o    (restart),
    .frame_o      (frame),
    .frame_valid_o(frame_valid)
  );

  // Mid-bit sample ticks, realigned on each start edge.
  uart_baud_gen u_baud (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .en_i      (rx_en_i),
    .baud_div_i(baud_div_i),
    .restart_i (restart),
    .tick_o    (tick)
  );

  // Nothing stalls the deserializer; a full FIFO drops the frame.
  uart_rx_fifo #(
    .DEPTH(`UART_FIFO_DEPTH)
  ) u_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wr_i     (frame_valid),
    .wdata_i  (frame),
    .rd_i     (rx_re_i),
    .rdata_o  (rdata_o),
    .empty_o  (empty_o),
    .full_o   (full_o),
    .overrun_o(overrun_o)
  );

endmodule

`default_nettype wire

// File: include/uart_params.svh
// Build-time constants for the UART receive path.
// Data width, default frame FIFO depth and line synchronizer depth.

`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Bits per character, no parity.
`define UART_DATA_W 8

// Default number of frames held for the host.
// Must be a power of two.
`define UART_FIFO_DEPTH 16

// Flops between the pin and the edge detector.
`define UART_SYNC_STAGES 2

`endif

// File: tests/uart_rx_tb.sv
// Testbench for the UART receive subsystem.
// Serial line driver, xorshift byte source, expected-frame queue,
// read-side checks, timeout and result reporting.

`include "uart_params.svh"

`default_nettype none

module uart_rx_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int BAUD_DIV   = 16;
  localparam int GLITCH_LEN = BAUD_DIV / 4;
  localparam int WAIT_LIM   = 11 * BAUD_DIV + `UART_SYNC_STAGES + 2;
  localparam int N_FRAMES   = 1 + 12 + 2 + (`UART_FIFO_DEPTH + 1) + 2;
  localparam int TIMEOUT    = 11 * BAUD_DIV * N_FRAMES + 2000;

  // Line driver modes.
  localparam int MODE_GOOD     = 0;
  localparam int MODE_BAD_STOP = 1;
  localparam int MODE_GLITCH   = 2;

  logic                clk_i;
  logic                rst_ni;
  logic                rx_en_i;
  uart_pkg::baud_div_t baud_div_i;
  logic                rx_i;
  logic                rx_re_i;
  uart_pkg::rx_frame_t rdata_o;
  logic                empty_o;
  logic                full_o;
  logic                overrun_o;

  uart_pkg::rx_frame_t expq[$];
  logic [31:0]         rng_state;
  int                  errors;
  int                  checks;
  int                  tests_run;
  int                  tests_failed;
  int                  cycles;
  int                  overrun_cnt;
  int                  errs_before;

  uart_rx_top DUT (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rx_en_i   (rx_en_i),
    .baud_div_i(baud_div_i),
    .rx_i      (rx_i),
    .rx_re_i   (rx_re_i),
    .rdata_o   (rdata_o),
    .empty_o   (empty_o),
    .full_o    (full_o),
    .overrun_o (overrun_o)
  );

  always #50 clk_i = ~clk_i;

  // Run limit scaled to the number of frames sent.
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles, the receiver stopped making progress", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Overrun is a combinational pulse, so count it mid-cycle.
  always @(negedge clk_i) begin
    if (rst_ni && overrun_o === 1'b1) begin
      overrun_cnt++;
    end
  end

  a_flags_sane : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (!overrun_o || full_o) && !(empty_o && full_o)
  ) else begin
    $display("FIFO flags inconsistent: overrun without full, or empty and full together");
    errors++;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_byte(output uart_pkg::data_t b);
    rng_state = xorshift32(rng_state);
    b = rng_state[`UART_DATA_W-1:0];
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("ERR %s: expected 0x%0h, got 0x%0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic drive_bit(input logic b);
    rx_i <= b;
    repeat (BAUD_DIV) @(posedge clk_i);
  endtask

  // One frame on the line, LSB first. A glitch is a short low pulse only.
  task automatic send_frame(input uart_pkg::data_t d, input int mode, input bit keep);
    uart_pkg::rx_frame_t f;
    int                  i;
    @(posedge clk_i);
    if (mode == MODE_GLITCH) begin
      rx_i <= 1'b0;
      repeat (GLITCH_LEN) @(posedge clk_i);
      rx_i <= 1'b1;
      repeat (BAUD_DIV * 10) @(posedge clk_i);
    end else begin
      f.data      = d;
      f.frame_err = (mode == MODE_BAD_STOP);
      if (keep) begin
        expq.push_back(f);
      end
      drive_bit(1'b0);
      for (i = 0; i < `UART_DATA_W; i++) begin
        drive_bit(d[i]);
      end
      drive_bit(mode != MODE_BAD_STOP);
      // Line must go idle again before a new start edge.
      if (mode == MODE_BAD_STOP) begin
        drive_bit(1'b1);
      end
    end
  endtask

  // Wait for a frame, compare the head with the queue and pop it.
  task automatic read_and_compare();
    uart_pkg::rx_frame_t exp;
    int                  waited;
    waited = 0;
    @(negedge clk_i);
    while (empty_o && waited < WAIT_LIM) begin
      @(negedge clk_i);
      waited++;
    end
    if (empty_o) begin
      $display("No frame arrived within %0d cycles", WAIT_LIM);
      errors++;
    end else if (expq.size() == 0) begin
      $display("A frame arrived that was never sent");
      errors++;
    end else begin
      exp = expq.pop_front();
      checks++;
      assert (rdata_o === exp) else begin
        $display("ERR rdata_o: expected 0x%0h, got 0x%0h", exp, rdata_o);
        errors++;
      end
      @(posedge clk_i);
      rx_re_i <= 1'b1;
      @(posedge clk_i);
      rx_re_i <= 1'b0;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == errs_before) begin
      $display("%-24s passed", name);
    end else begin
      tests_failed++;
      $display("%-24s failed with %0d errors", name, errors - errs_before);
    end
    errs_before = errors;
  endtask

  initial begin
    uart_pkg::data_t b;
    int              i;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    rx_en_i      = 1'b0;
    baud_div_i   = 16'(BAUD_DIV);
    rx_i         = 1'b1;
    rx_re_i      = 1'b0;
    rng_state    = 32'd55098;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycles       = 0;
    overrun_cnt  = 0;
    errs_before  = 0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Reset values, then an idle line with the receiver on.
    @(negedge clk_i);
    check_value("empty_o", 1, empty_o);
    check_value("full_o", 0, full_o);
    check_value("overrun_o", 0, overrun_o);
    @(posedge clk_i);
    rx_en_i <= 1'b1;
    repeat (WAIT_LIM) @(posedge clk_i);
    @(negedge clk_i);
    check_value("empty_o", 1, empty_o);
    report_test("reset state");

    fork
      send_frame(8'h5a, MODE_GOOD, 1'b1);
      read_and_compare();
    join
    @(negedge clk_i);
    check_value("empty_o", 1, empty_o);
    report_test("single frame");

    fork
      begin
        for (i = 0; i < 12; i++) begin
          next_byte(b);
          send_frame(b, MODE_GOOD, 1'b1);
        end
      end
      begin
        for (int k = 0; k < 12; k++) begin
          read_and_compare();
        end
      end
    join
    report_test("random burst");

    fork
      send_frame(8'hc3, MODE_BAD_STOP, 1'b1);
      read_and_compare();
    join
    send_frame('0, MODE_GLITCH, 1'b0);
    @(negedge clk_i);
    check_value("empty_o", 1, empty_o);
    report_test("framing error, glitch");

    // Fill past the depth with no reads; the last frame is dropped.
    overrun_cnt = 0;
    for (i = 0; i < `UART_FIFO_DEPTH + 1; i++) begin
      next_byte(b);
      send_frame(b, MODE_GOOD, i < `UART_FIFO_DEPTH);
    end
    @(negedge clk_i);
    check_value("full_o", 1, full_o);
    check_value("overrun_o pulses", 1, overrun_cnt);
    for (i = 0; i < `UART_FIFO_DEPTH; i++) begin
      read_and_compare();
    end
    @(negedge clk_i);
    check_value("empty_o", 1, empty_o);
    report_test("overrun");

    @(posedge clk_i);
    rx_en_i <= 1'b0;
    send_frame(8'ha5, MODE_GOOD, 1'b0);
    repeat (BAUD_DIV * 2) @(posedge clk_i);
    @(negedge clk_i);
    check_value("empty_o", 1, empty_o);
    @(posedge clk_i);
    rx_en_i <= 1'b1;
    repeat (BAUD_DIV) @(posedge clk_i);
    fork
      send_frame(8'h3c, MODE_GOOD, 1'b1);
      read_and_compare();
    join
    report_test("disable");

    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_rx_deser.sv
hw/uart_rx_fifo.sv
hw/uart_rx_top.sv
tests/uart_rx_tb.sv
